// ==== test/cart_patterns.txt ====
# name kind addr_hi addr_lo data exp aux, all numbers in hex
# R, W: exp = data_out[7:0], aux = {TFPow, FastClkEnable, nMCUReset, data_oe_lo}
# W writes data[7:0] and then reads the same register back
# M: data[16] picks WE over OE, data[15:0] = data_in
# M: exp = {nPSRAM1Sel, nPSRAM2Sel, nSRAMSel, PSRAM_nLB, PSRAM_nUB, AddrExt}
# M: aux = {data_oe_hi, data_oe_lo, high byte if driven, low byte if driven}
rst_ram_bank R C 1 0000 FF 3
rst_pow_cnt R E 2 0000 C5 3
rst_mask_lo R E 4 0000 FF 3
rd_unknown R C F 0000 00 2
wr_rom0_2001 W C 2 0005 05 3
wr_rom0_high W D 3 00FD 01 3
wr_rom1_low W D 4 0083 83 3
wr_rom1_high W D 5 0000 00 3
wr_linear W C 0 0002 02 3
wr_ram_2001 W C 1 0002 02 3
wr_ram_high W D 1 0002 02 3
rd_ram_low R D 0 0000 02 3
map_rom0_nochip M 2 0 00000 E05 00000
map_rom1_psram2 M 3 0 00000 A03 00000
map_linear_4 M 4 0 00000 624 00000
map_linear_f_wr M F 0 11234 62F 00000
wr_mask_lo W E 4 007F 7F 3
wr_mask_hi W E 5 00FE FE 3
map_rom0_masked M 2 0 00000 605 00000
map_rom1_masked M 3 0 00000 603 00000
wr_mask_no_rom1 W E 5 00FA FA 3
map_rom1_bypass M 3 0 00000 A03 00000
map_rom0_kept M 2 0 00000 605 00000
map_ram_sram M 1 0 00000 C82 00000
map_ram_sram_odd M 1 1 00000 D02 00000
wr_ram_bank_0a W C 1 000A 0A 3
map_ram_bit3 M 1 0 00000 E8A 00000
wr_mask_ram W E 5 007A 7A 3
map_ram_masked M 1 0 00000 C8A 00000
wr_pow_no_sram W E 2 0083 87 B
map_ram_no_sram M 1 0 00000 E8A 00000
wr_self_flash W C E 0001 01 B
map_flash_even M 1 0 05AC3 68A 00000
map_flash_odd_rd M 1 1 05AC3 70A 1005A
map_flash_odd_wr M 1 1 13C96 70A 29600
wr_pow_mcu_reset W E 2 0041 45 1
wr_pow_fast_clk W E 2 00C2 C6 F
wr_pow_unlock W E 2 00FD C5 3

// ==== all.f ====
hdl/cart_regs_pkg.sv
hdl/cart_map_pkg.sv
hdl/cart_ifs.sv
hdl/bus_front.sv
hdl/cart_reg_file.sv
hdl/mem_mapper.sv
hdl/bus_drive.sv
hdl/cart_mapper_top.sv
test/cart_mapper_checker.sv
test/tb_cart_mapper.sv

// ==== Makefile ====
# Verilator simulation of the cartridge mapper testbench

TOP := tb_cart_mapper

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== test/tb_cart_mapper.sv ====
`default_nettype none

module tb_cart_mapper;

    localparam int MAX_LINES = 200;
    localparam int MAX_WAIT  = 64;

    logic        SClk;
    logic        rst_n;
    logic        nSel;
    logic        nOE;
    logic        nWE;
    logic        nIO;
    logic [8:0]  AddrLo;
    logic [3:0]  AddrHi;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic        data_oe_lo;
    logic        data_oe_hi;
    logic [6:0]  AddrExt;
    logic        nMem_OE;
    logic        nMem_WE;
    logic        nPSRAM1Sel;
    logic        nPSRAM2Sel;
    logic        nSRAMSel;
    logic        PSRAM_nLB;
    logic        PSRAM_nUB;
    logic        FastClkEnable;
    logic        TFPow;
    logic        nMCUReset;

    integer      seed;
    int          fd;
    int          code;
    int          cnt;
    int          n_lines;
    int          n_pass;
    int          n_fail;
    bit          test_ok;
    string       line;
    string       name;
    string       kind;
    logic [3:0]  hi;
    logic [8:0]  lo;
    logic [19:0] data;
    logic [15:0] exp_v;
    logic [17:0] aux_v;
    logic [31:0] rnd;

    cart_mapper_top dut (.*);

    initial begin
        SClk = 1'b0;
        forever #4 SClk = ~SClk;
    end

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n && i < MAX_WAIT; i++) begin
            @(posedge SClk);
        end
    endtask

    task automatic set_idle();
        nSel    = 1'b1;
        nOE     = 1'b1;
        nWE     = 1'b1;
        nIO     = 1'b1;
        AddrHi  = 4'h0;
        AddrLo  = 9'h000;
        data_in = 16'h0000;
    endtask

    task automatic check_value(input string what, input logic [19:0] exp,
                               input logic [19:0] got);
        assert (got === exp) else begin
            $display("ERROR %s %s: expected %h actual %h", name, what, exp, got);
            test_ok = 1'b0;
        end
    endtask

    task automatic read_register(input logic [3:0] a_hi, input logic [8:0] a_lo,
                                 input logic [7:0] exp_data, input logic [3:0] exp_pins);
        wait_cycles(1);
        #1;
        AddrHi = a_hi;
        AddrLo = a_lo;
        nSel   = 1'b0;
        nIO    = 1'b0;
        nOE    = 1'b0;
        // sample mid cycle, well after the drive point
        #3;
        check_value("data", {12'h000, exp_data}, {12'h000, data_out[7:0]});
        check_value("pins", {16'h0000, exp_pins},
                    {16'h0000, TFPow, FastClkEnable, nMCUReset, data_oe_lo});
        wait_cycles(1);
        #1;
        set_idle();
    endtask

    task automatic write_register(input logic [3:0] a_hi, input logic [8:0] a_lo,
                                  input logic [15:0] wdata, input logic [7:0] exp_data,
                                  input logic [3:0] exp_pins);
        wait_cycles(1);
        #1;
        AddrHi  = a_hi;
        AddrLo  = a_lo;
        data_in = wdata;
        nSel    = 1'b0;
        nIO     = 1'b0;
        nWE     = 1'b0;
        wait_cycles(2);
        #1;
        nWE = 1'b1;
        // the console keeps address and data on the bus after the strobe
        wait_cycles(6);
        #1;
        set_idle();
        read_register(a_hi, a_lo, exp_data, exp_pins);
    endtask

    task automatic map_access(input logic [3:0] a_hi, input logic [8:0] a_lo,
                              input logic [19:0] acc, input logic [11:0] exp_map,
                              input logic [17:0] exp_bus);
        wait_cycles(1);
        #1;
        AddrHi  = a_hi;
        AddrLo  = a_lo;
        data_in = acc[15:0];
        nSel    = 1'b0;
        nIO     = 1'b1;
        if (acc[16]) begin
            nWE = 1'b0;
        end else begin
            nOE = 1'b0;
        end
        #3;
        check_value("map", {8'h00, exp_map},
                    {8'h00, nPSRAM1Sel, nPSRAM2Sel, nSRAMSel, PSRAM_nLB, PSRAM_nUB, AddrExt});
        // the memory strobes follow the access direction
        check_value("strobes", {18'h00000, acc[16], ~acc[16]},
                    {18'h00000, nMem_OE, nMem_WE});
        // bytes not driven onto the bus count as zero
        check_value("bus", {2'b00, exp_bus},
                    {2'b00, data_oe_hi, data_oe_lo,
                     data_oe_hi ? data_out[15:8] : 8'h00,
                     data_oe_lo ? data_out[7:0] : 8'h00});
        wait_cycles(1);
        #1;
        set_idle();
    endtask

    initial begin
        seed    = 32'h016f2841;
        n_lines = 0;
        n_pass  = 0;
        n_fail  = 0;
        rst_n   = 1'b0;
        set_idle();
        wait_cycles(2);
        #1;
        rst_n = 1'b1;

        fd = $fopen("test/cart_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file test/cart_patterns.txt");
            n_fail++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                n_lines++;
                line = "";
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%s %s %h %h %h %h %h",
                              name, kind, hi, lo, data, exp_v, aux_v);
                if (cnt != 7) begin
                    $display("pattern line %0d is malformed", n_lines);
                    n_fail++;
                    continue;
                end
                test_ok = 1'b1;
                rnd = $random(seed);
                if (kind == "W") begin
                    write_register(hi, {rnd[8:4], lo[3:0]}, data[15:0], exp_v[7:0], aux_v[3:0]);
                end else if (kind == "R") begin
                    read_register(hi, {rnd[8:4], lo[3:0]}, exp_v[7:0], aux_v[3:0]);
                end else if (kind == "M") begin
                    map_access(hi, {rnd[8:1], lo[0]}, data, exp_v[11:0], aux_v);
                end else begin
                    $display("test %s has an unknown kind %s", name, kind);
                    test_ok = 1'b0;
                end
                if (test_ok) begin
                    n_pass++;
                    $display("PASS %s", name);
                end else begin
                    n_fail++;
                    $display("FAIL %s", name);
                end
            end
            if (!$feof(fd)) begin
                $display("pattern file has more than %0d lines", MAX_LINES);
                n_fail++;
            end
            $fclose(fd);
        end

        if (dut.u_checker.assert_fails != 0) begin
            $display("bus checker saw %0d assertion failures", dut.u_checker.assert_fails);
        end
        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0 && dut.u_checker.assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/cart_mapper_checker.sv ====
`default_nettype none

module cart_mapper_checker (
    input wire logic SClk,
    input wire logic rst_n,
    input wire logic nSel,
    input wire logic nOE,
    input wire logic nPSRAM1Sel,
    input wire logic nPSRAM2Sel,
    input wire logic nSRAMSel,
    input wire logic data_oe_lo
);

    int assert_fails = 0;

    // the memory chips share one data bus
    one_chip_select: assert property (@(posedge SClk) disable iff (!rst_n)
        $countones({~nPSRAM1Sel, ~nPSRAM2Sel, ~nSRAMSel}) <= 1)
    else begin
        assert_fails++;
        $error("more than one memory chip select is low");
    end

    no_select_idle: assert property (@(posedge SClk) disable iff (!rst_n)
        nSel |-> (nPSRAM1Sel && nPSRAM2Sel && nSRAMSel))
    else begin
        assert_fails++;
        $error("a memory chip select is low while the cartridge is not selected");
    end

    no_drive_idle: assert property (@(posedge SClk) disable iff (!rst_n)
        (nSel && nOE) |-> !data_oe_lo)
    else begin
        assert_fails++;
        $error("low data byte driven with neither select nor output enable");
    end

endmodule

bind cart_mapper_top cart_mapper_checker u_checker (
    .SClk       (SClk),
    .rst_n      (rst_n),
    .nSel       (nSel),
    .nOE        (nOE),
    .nPSRAM1Sel (nPSRAM1Sel),
    .nPSRAM2Sel (nPSRAM2Sel),
    .nSRAMSel   (nSRAMSel),
    .data_oe_lo (data_oe_lo)
);

`default_nettype wire

// ==== hdl/cart_mapper_top.sv ====
`default_nettype none

module cart_mapper_top (
    input  wire logic        SClk,
    input  wire logic        rst_n,
    input  wire logic        nSel,
    input  wire logic        nOE,
    input  wire logic        nWE,
    input  wire logic        nIO,
    input  wire logic [8:0]  AddrLo,
    input  wire logic [3:0]  AddrHi,
    input  wire logic [15:0] data_in,
    output logic [15:0]      data_out,
    output logic             data_oe_lo,
    output logic             data_oe_hi,
    output logic [cart_map_pkg::ADDR_EXT_W-1:0] AddrExt,
    output logic             nMem_OE,
    output logic             nMem_WE,
    output logic             nPSRAM1Sel,
    output logic             nPSRAM2Sel,
    output logic             nSRAMSel,
    output logic             PSRAM_nLB,
    output logic             PSRAM_nUB,
    output logic             FastClkEnable,
    output logic             TFPow,
    output logic             nMCUReset
);

    logic [7:0] reg_rdata;
    logic       reg_ack;
    logic       fastclk_enable;
    logic       ram_area_psram;

    cart_bus_if bus_if ();
    bank_cfg_if cfg_if ();

    bus_front u_bus_front (
        .SClk    (SClk),
        .rst_n   (rst_n),
        .nSel    (nSel),
        .nOE     (nOE),
        .nWE     (nWE),
        .nIO     (nIO),
        .AddrHi  (AddrHi),
        .AddrLo  (AddrLo),
        .data_in (data_in),
        .bus     (bus_if.front)
    );

    cart_reg_file u_reg_file (
        .SClk           (SClk),
        .rst_n          (rst_n),
        .bus            (bus_if.regs),
        .cfg            (cfg_if.owner),
        .reg_rdata      (reg_rdata),
        .reg_ack        (reg_ack),
        .fastclk_enable (fastclk_enable),
        .tf_power       (TFPow),
        .mcu_reset_n    (nMCUReset)
    );

    mem_mapper u_mem_mapper (
        .bus            (bus_if.map),
        .cfg            (cfg_if.user),
        .nSel           (nSel),
        .nIO            (nIO),
        .AddrExt        (AddrExt),
        .nPSRAM1Sel     (nPSRAM1Sel),
        .nPSRAM2Sel     (nPSRAM2Sel),
        .nSRAMSel       (nSRAMSel),
        .PSRAM_nLB      (PSRAM_nLB),
        .PSRAM_nUB      (PSRAM_nUB),
        .ram_area_psram (ram_area_psram)
    );

    bus_drive u_bus_drive (
        .bus            (bus_if.drive),
        .data_in        (data_in),
        .reg_rdata      (reg_rdata),
        .reg_ack        (reg_ack),
        .ram_area_psram (ram_area_psram),
        .nSel           (nSel),
        .data_out       (data_out),
        .data_oe_lo     (data_oe_lo),
        .data_oe_hi     (data_oe_hi)
    );

    // memory strobes pass straight to the chips
    assign nMem_OE       = nOE;
    assign nMem_WE       = nWE;
    assign FastClkEnable = ~fastclk_enable;

endmodule

`default_nettype wire

// ==== hdl/bus_drive.sv ====
`default_nettype none

module bus_drive (
    cart_bus_if.drive       bus,
    input  wire logic [15:0] data_in,
    input  wire logic [7:0]  reg_rdata,
    input  wire logic        reg_ack,
    input  wire logic        ram_area_psram,
    input  wire logic        nSel,
    output logic [15:0]      data_out,
    output logic             data_oe_lo,
    output logic             data_oe_hi
);

    logic psram_hi_read;
    logic psram_hi_write;
    logic reg_out;

    // 8-bit accesses to odd addresses use the upper PSRAM lane
    assign psram_hi_read  = bus.mem_cycle & ram_area_psram & bus.oe_act & bus.lane_odd;
    assign psram_hi_write = bus.mem_cycle & ram_area_psram & bus.we_act & bus.lane_odd;
    assign reg_out        = ~nSel & bus.io_rd & reg_ack;

    assign data_out[7:0]  = psram_hi_read ? data_in[15:8] : reg_rdata;
    assign data_out[15:8] = psram_hi_write ? data_in[7:0] : 8'h00;

    assign data_oe_lo = reg_out | psram_hi_read;
    assign data_oe_hi = psram_hi_write;

endmodule

`default_nettype wire

// ==== hdl/mem_mapper.sv ====
`default_nettype none

module mem_mapper (
    cart_bus_if.map  bus,
    bank_cfg_if.user cfg,
    input  wire logic nSel,
    input  wire logic nIO,
    output logic [cart_map_pkg::ADDR_EXT_W-1:0] AddrExt,
    output logic     nPSRAM1Sel,
    output logic     nPSRAM2Sel,
    output logic     nSRAMSel,
    output logic     PSRAM_nLB,
    output logic     PSRAM_nUB,
    output logic     ram_area_psram
);
    import cart_regs_pkg::*;
    import cart_map_pkg::*;

    area_e                 area;
    logic [3:0]            area_nib;
    logic [ROM_BANK_W-1:0] bank_sel;
    logic [ROM_BANK_W-1:0] rom_masked;
    logic [RAM_MASK_W-1:0] ram_masked;
    logic                  apply_mask;
    logic                  rom_space;
    logic                  ram_space;
    logic                  in_ram_area;
    logic                  psram1_hit;
    logic                  psram2_hit;
    logic                  sram_hit;
    logic                  strobe;

    assign area_nib = bus.reg_addr[7:4];

    always_comb begin
        case (area_nib)
            4'h0:    area = AREA_IO_NONE;
            4'h1:    area = AREA_RAM;
            4'h2:    area = AREA_ROM0;
            4'h3:    area = AREA_ROM1;
            default: area = AREA_LINEAR;
        endcase
    end

    always_comb begin
        bank_sel   = '0;
        apply_mask = 1'b1;
        rom_space  = 1'b0;
        ram_space  = 1'b0;
        case (area)
            AREA_RAM: begin
                // self flash remaps the ram window onto rom space
                rom_space  = cfg.self_flash;
                ram_space  = ~cfg.self_flash;
                bank_sel   = cfg.ram_bank[ROM_BANK_W-1:0];
                apply_mask = cfg.apply_ram;
            end
            AREA_ROM0: begin
                rom_space  = 1'b1;
                bank_sel   = cfg.rom0_bank[ROM_BANK_W-1:0];
                apply_mask = cfg.apply_rom0;
            end
            AREA_ROM1: begin
                rom_space  = 1'b1;
                bank_sel   = cfg.rom1_bank[ROM_BANK_W-1:0];
                apply_mask = cfg.apply_rom1;
            end
            AREA_LINEAR: begin
                rom_space = 1'b1;
                bank_sel  = {cfg.linear_bank[4:0], area_nib};
            end
            default: ;
        endcase
    end

    assign in_ram_area = (area == AREA_RAM);
    assign rom_masked  = apply_mask ? (bank_sel & cfg.rom_mask) : bank_sel;
    assign ram_masked  = apply_mask ? (cfg.ram_bank[RAM_MASK_W-1:0] & cfg.ram_mask)
                                    : cfg.ram_bank[RAM_MASK_W-1:0];

    assign psram1_hit = rom_space && rom_masked[8:7] == PSRAM1_TOP2;
    assign psram2_hit = rom_space && rom_masked[8:7] == PSRAM2_TOP2;
    assign sram_hit   = ram_space && !ram_masked[SRAM_BANK_BIT] && cfg.enable_sram;

    assign strobe     = ~nSel & nIO & (bus.oe_act | bus.we_act);
    assign nPSRAM1Sel = ~(strobe & psram1_hit);
    assign nPSRAM2Sel = ~(strobe & psram2_hit);
    assign nSRAMSel   = ~(strobe & sram_hit);

    // sram only decodes the low three bank bits
    assign AddrExt[2:0]            = rom_space ? rom_masked[2:0] : ram_masked[2:0];
    assign AddrExt[ADDR_EXT_W-1:3] = rom_masked[ADDR_EXT_W-1:3];

    assign PSRAM_nLB      = in_ram_area & bus.lane_odd;
    assign PSRAM_nUB      = in_ram_area & ~bus.lane_odd;
    assign ram_area_psram = in_ram_area & (psram1_hit | psram2_hit);

endmodule

`default_nettype wire

// ==== hdl/cart_reg_file.sv ====
`default_nettype none

module cart_reg_file (
    input  wire logic  SClk,
    input  wire logic  rst_n,
    cart_bus_if.regs   bus,
    bank_cfg_if.owner  cfg,
    output logic [7:0] reg_rdata,
    output logic       reg_ack,
    output logic       fastclk_enable,
    output logic       tf_power,
    output logic       mcu_reset_n
);
    import cart_regs_pkg::*;

    logic [BANK_W-1:0]     ram_bank;
    logic [BANK_W-1:0]     rom0_bank;
    logic [BANK_W-1:0]     rom1_bank;
    logic [7:0]            linear_bank;
    logic [ROM_BANK_W-1:0] rom_mask;
    logic [RAM_MASK_W-1:0] ram_mask;
    logic                  apply_rom0;
    logic                  apply_rom1;
    logic                  apply_ram;
    logic                  self_flash;
    logic                  enable_sram;
    wr_byte_u              wb;

    assign wb = bus.wdata;

    always_ff @(posedge SClk or negedge rst_n) begin
        if (!rst_n) begin
            ram_bank       <= '1;
            rom0_bank      <= '1;
            rom1_bank      <= '1;
            linear_bank    <= '1;
            rom_mask       <= '1;
            ram_mask       <= '1;
            apply_rom0     <= 1'b1;
            apply_rom1     <= 1'b1;
            apply_ram      <= 1'b1;
            self_flash     <= 1'b0;
            enable_sram    <= 1'b1;
            fastclk_enable <= 1'b1;
            tf_power       <= 1'b0;
            mcu_reset_n    <= 1'b1;
        end else if (bus.io_wr_pulse) begin
            case (bus.reg_addr)
                LINEAR_ADDR_OFF:          linear_bank    <= wb.raw;
                RAM_BANK, RAM_BANK_L:     ram_bank[7:0]  <= wb.raw;
                ROM_BANK_0, ROM_BANK_0_L: rom0_bank[7:0] <= wb.raw;
                ROM_BANK_1, ROM_BANK_1_L: rom1_bank[7:0] <= wb.raw;
                // high halves only hold the two top bank bits
                RAM_BANK_H:   ram_bank[9:8]  <= wb.raw[1:0];
                ROM_BANK_0_H: rom0_bank[9:8] <= wb.raw[1:0];
                ROM_BANK_1_H: rom1_bank[9:8] <= wb.raw[1:0];
                MEMORY_CTRL:  self_flash     <= wb.raw[0];
                BANK_MASK_LO: rom_mask[7:0]  <= wb.raw;
                BANK_MASK_HI: begin
                    rom_mask[8] <= wb.mask_hi.rom_mask_8;
                    apply_rom0  <= wb.mask_hi.apply_rom0;
                    apply_rom1  <= wb.mask_hi.apply_rom1;
                    apply_ram   <= wb.mask_hi.apply_ram;
                    ram_mask    <= wb.mask_hi.ram_mask;
                end
                POW_CNT: begin
                    fastclk_enable <= wb.pow.fastclk;
                    tf_power       <= wb.pow.tf_power;
                    enable_sram    <= wb.pow.enable_sram;
                    mcu_reset_n    <= wb.pow.mcu_reset_n;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        reg_ack   = 1'b1;
        reg_rdata = 8'h00;
        case (bus.reg_addr)
            LINEAR_ADDR_OFF:          reg_rdata = linear_bank;
            RAM_BANK, RAM_BANK_L:     reg_rdata = ram_bank[7:0];
            ROM_BANK_0, ROM_BANK_0_L: reg_rdata = rom0_bank[7:0];
            ROM_BANK_1, ROM_BANK_1_L: reg_rdata = rom1_bank[7:0];
            RAM_BANK_H:   reg_rdata = {6'h00, ram_bank[9:8]};
            ROM_BANK_0_H: reg_rdata = {6'h00, rom0_bank[9:8]};
            ROM_BANK_1_H: reg_rdata = {6'h00, rom1_bank[9:8]};
            MEMORY_CTRL:  reg_rdata = {7'h00, self_flash};
            BANK_MASK_LO: reg_rdata = rom_mask[7:0];
            BANK_MASK_HI: reg_rdata = {ram_mask, apply_ram, apply_rom1, apply_rom0, rom_mask[8]};
            // extension registers are always enabled on this cartridge
            POW_CNT: reg_rdata = {mcu_reset_n, enable_sram, 3'b000, 1'b1,
                                  tf_power, fastclk_enable};
            default: reg_ack = 1'b0;
        endcase
    end

    assign cfg.ram_bank    = ram_bank;
    assign cfg.rom0_bank   = rom0_bank;
    assign cfg.rom1_bank   = rom1_bank;
    assign cfg.linear_bank = linear_bank;
    assign cfg.rom_mask    = rom_mask;
    assign cfg.ram_mask    = ram_mask;
    assign cfg.apply_rom0  = apply_rom0;
    assign cfg.apply_rom1  = apply_rom1;
    assign cfg.apply_ram   = apply_ram;
    assign cfg.self_flash  = self_flash;
    assign cfg.enable_sram = enable_sram;

endmodule

`default_nettype wire

// ==== hdl/bus_front.sv ====
`default_nettype none

module bus_front (
    input  wire logic       SClk,
    input  wire logic       rst_n,
    input  wire logic       nSel,
    input  wire logic       nOE,
    input  wire logic       nWE,
    input  wire logic       nIO,
    input  wire logic [3:0] AddrHi,
    input  wire logic [8:0] AddrLo,
    input  wire logic [15:0] data_in,
    cart_bus_if.front       bus
);
    import cart_regs_pkg::*;

    logic [1:0]            nwe_sync;
    logic                  wr_io_q;
    logic                  wr_pulse_q;
    logic [REG_ADDR_W-1:0] wr_addr_q;
    logic [7:0]            wr_data_q;
    logic [REG_ADDR_W-1:0] live_addr;

    assign live_addr = {AddrHi, AddrLo[3:0]};

    always_ff @(posedge SClk or negedge rst_n) begin
        if (!rst_n) begin
            nwe_sync   <= 2'b11;
            wr_io_q    <= 1'b0;
            wr_pulse_q <= 1'b0;
        end else begin
            nwe_sync   <= {nwe_sync[0], nWE};
            // rising edge of the synchronised strobe ends the write
            wr_pulse_q <= nwe_sync[0] & ~nwe_sync[1] & wr_io_q;
            // sampled one stage early so even a one cycle strobe sets it in time
            if (!nwe_sync[0]) begin
                wr_io_q <= ~nSel & ~nIO;
            end
        end
    end

    always_ff @(posedge SClk) begin
        if (!nwe_sync[1]) begin
            wr_addr_q <= live_addr;
            wr_data_q <= data_in[7:0];
        end
    end

    assign bus.io_wr_pulse = wr_pulse_q;
    assign bus.reg_addr    = wr_pulse_q ? wr_addr_q : live_addr;
    assign bus.wdata       = wr_data_q;
    assign bus.io_rd       = ~nIO & ~nOE;
    assign bus.mem_cycle   = ~nSel & nIO;
    assign bus.oe_act      = ~nOE;
    assign bus.we_act      = ~nWE;
    assign bus.lane_odd    = AddrLo[0];

endmodule

`default_nettype wire

// ==== hdl/cart_ifs.sv ====
`default_nettype none

interface cart_bus_if;
    import cart_regs_pkg::*;

    logic                  io_wr_pulse;
    logic                  io_rd;
    logic                  mem_cycle;
    logic                  oe_act;
    logic                  we_act;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [7:0]            wdata;
    logic                  lane_odd;

    modport front (
        output io_wr_pulse, io_rd, mem_cycle, oe_act, we_act, reg_addr, wdata, lane_odd
    );
    modport regs  (input io_wr_pulse, reg_addr, wdata);
    modport map   (input oe_act, we_act, reg_addr, lane_odd);
    modport drive (input io_rd, mem_cycle, oe_act, we_act, lane_odd);
endinterface

interface bank_cfg_if;
    import cart_regs_pkg::*;

    logic [BANK_W-1:0]     ram_bank;
    logic [BANK_W-1:0]     rom0_bank;
    logic [BANK_W-1:0]     rom1_bank;
    logic [7:0]            linear_bank;
    logic [ROM_BANK_W-1:0] rom_mask;
    logic [RAM_MASK_W-1:0] ram_mask;
    logic                  apply_rom0;
    logic                  apply_rom1;
    logic                  apply_ram;
    logic                  self_flash;
    logic                  enable_sram;

    modport owner (
        output ram_bank, rom0_bank, rom1_bank, linear_bank, rom_mask, ram_mask,
        output apply_rom0, apply_rom1, apply_ram, self_flash, enable_sram
    );
    modport user (
        input ram_bank, rom0_bank, rom1_bank, linear_bank, rom_mask, ram_mask,
        input apply_rom0, apply_rom1, apply_ram, self_flash, enable_sram
    );
endinterface

`default_nettype wire

// ==== hdl/cart_map_pkg.sv ====
`default_nettype none

package cart_map_pkg;

    // decoded meaning of the AddrHi nibble, linear covers 4 to F
    typedef enum logic [2:0] {
        AREA_IO_NONE = 3'd0,
        AREA_RAM     = 3'd1,
        AREA_ROM0    = 3'd2,
        AREA_ROM1    = 3'd3,
        AREA_LINEAR  = 3'd4
    } area_e;

    localparam int ADDR_EXT_W = 7;

    // masked rom bank bits 8:7 per PSRAM chip
    localparam logic [1:0] PSRAM1_TOP2 = 2'd0;
    localparam logic [1:0] PSRAM2_TOP2 = 2'd1;

    // ram banks with this bit set are not backed by SRAM
    localparam int SRAM_BANK_BIT = 3;

endpackage

`default_nettype wire

// ==== hdl/cart_regs_pkg.sv ====
`default_nettype none

package cart_regs_pkg;

    localparam int REG_ADDR_W = 8;
    localparam int BANK_W     = 10;
    localparam int ROM_BANK_W = 9;
    localparam int RAM_MASK_W = 4;

    // 2001 register set
    localparam logic [REG_ADDR_W-1:0] LINEAR_ADDR_OFF = 8'hC0;
    localparam logic [REG_ADDR_W-1:0] RAM_BANK        = 8'hC1;
    localparam logic [REG_ADDR_W-1:0] ROM_BANK_0      = 8'hC2;
    localparam logic [REG_ADDR_W-1:0] ROM_BANK_1      = 8'hC3;

    // 2003 register set
    localparam logic [REG_ADDR_W-1:0] MEMORY_CTRL  = 8'hCE;
    localparam logic [REG_ADDR_W-1:0] RAM_BANK_L   = 8'hD0;
    localparam logic [REG_ADDR_W-1:0] RAM_BANK_H   = 8'hD1;
    localparam logic [REG_ADDR_W-1:0] ROM_BANK_0_L = 8'hD2;
    localparam logic [REG_ADDR_W-1:0] ROM_BANK_0_H = 8'hD3;
    localparam logic [REG_ADDR_W-1:0] ROM_BANK_1_L = 8'hD4;
    localparam logic [REG_ADDR_W-1:0] ROM_BANK_1_H = 8'hD5;

    // cartridge extension registers
    localparam logic [REG_ADDR_W-1:0] POW_CNT      = 8'hE2;
    localparam logic [REG_ADDR_W-1:0] BANK_MASK_LO = 8'hE4;
    localparam logic [REG_ADDR_W-1:0] BANK_MASK_HI = 8'hE5;

    // written to POW_CNT by software that does not know the extension state
    localparam logic [7:0] POW_UNLOCK = 8'hFD;

    typedef struct packed {
        logic [RAM_MASK_W-1:0] ram_mask;
        logic                  apply_ram;
        logic                  apply_rom1;
        logic                  apply_rom0;
        logic                  rom_mask_8;
    } mask_hi_t;

    typedef struct packed {
        logic       mcu_reset_n;
        logic       enable_sram;
        logic [3:0] ext_bits;
        logic       tf_power;
        logic       fastclk;
    } pow_cnt_t;

    typedef union packed {
        logic [7:0] raw;
        mask_hi_t   mask_hi;
        pow_cnt_t   pow;
    } wr_byte_u;

endpackage

`default_nettype wire
